//--- flist.f
+incdir+verilog
verilog/riscv_pkg.sv
verilog/ifetch.sv
verilog/dec.sv
verilog/rf.sv
verilog/exe.sv
verilog/core.sv
tests/tb_clk_gen.sv
tests/core_checker.sv
tests/core_assert.sv
tests/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

test: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/core_tb.sv
`timescale 1ns/1ps
`include "riscv_defines.svh"

module core_tb;
  import riscv_pkg::*;

  localparam int KIND_NONE  = 0;
  localparam int KIND_WBK   = 1;
  localparam int KIND_STORE = 2;
  localparam int BOOT_IDX   = 64;
  localparam int WAIT_CYC   = 600;

  typedef struct packed {
    logic [31:0] instr;
    logic [1:0]  kind;
    logic [4:0]  rd;
    logic [31:0] data;
    logic [31:0] adr;
  } row_t;

  logic             clk;
  logic             rst_n;
  logic [`XLEN-1:0] reset_adr;
  logic [`XLEN-1:0] icache_adr;
  logic [31:0]      icache_instr;
  mem_req_t         mem_req;
  logic [`XLEN-1:0] load_data;
  wbk_t             wbk;
  logic [`XLEN-1:0] pc_val;
  logic             chk_done;
  int               chk_errs;
  logic [31:0]      imem [0:255];
  logic [31:0]      dmem [0:255];
  row_t             prog [0:63];
  int               n_rows;
  int               wait_cnt;
  int               total_errs;

  tb_clk_gen #(.PERIOD_NS(100), .RST_CYCLES(8)) u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  core core_inst (
    .clk            (clk),
    .rst_n_i        (rst_n),
    .reset_adr_i    (reset_adr),
    .icache_adr_o   (icache_adr),
    .icache_instr_i (icache_instr),
    .mem_req_o      (mem_req),
    .load_data_i    (load_data),
    .wbk_o          (wbk),
    .pc_val_o       (pc_val)
  );

  core_checker #(.TIMEOUT_CYC(400)) u_checker (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .reset_adr_i  (reset_adr),
    .icache_adr_i (icache_adr),
    .mem_req_i    (mem_req),
    .wbk_i        (wbk),
    .pc_val_i     (pc_val),
    .done_o       (chk_done),
    .err_cnt_o    (chk_errs)
  );

  bind core core_assert u_core_assert (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .icache_adr_i (icache_adr_o),
    .mem_req_i    (mem_req_o),
    .wbk_i        (wbk_o)
  );

  // --------------------
  // memory models
  // --------------------
  assign icache_instr = imem[icache_adr[9:2]];
  assign load_data    = dmem[mem_req.adr[9:2]];

  always @(posedge clk) begin
    if (rst_n && mem_req.valid && mem_req.is_store) begin
      dmem[mem_req.adr[9:2]] <= mem_req.store_data;
    end
  end

  // --------------------
  // instruction encoders
  // --------------------
  function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, int opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] s_type(int imm, int rs2, int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(int imm20, int rd, int opc);
    return {imm20[19:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] j_type(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  task automatic add_row(logic [31:0] instr, int kind, int rd, logic [31:0] data,
                         logic [31:0] adr);
    prog[n_rows] = {instr, kind[1:0], rd[4:0], data, adr};
    n_rows++;
  endtask

  // program at 0x100 with expected results per row
  task automatic build_program();
    add_row(i_type(5, 0, 0, 1, 'h13), KIND_WBK, 1, 32'h5, 0);
    add_row(i_type(3, 1, 0, 2, 'h13), KIND_WBK, 2, 32'h8, 0);
    add_row(r_type(0, 2, 1, 0, 3), KIND_WBK, 3, 32'hd, 0);
    add_row(r_type('h20, 1, 3, 0, 4), KIND_WBK, 4, 32'h8, 0);
    add_row(i_type(7, 0, 0, 0, 'h13), KIND_NONE, 0, 0, 0);
    add_row(i_type('hfff, 4, 4, 5, 'h13), KIND_WBK, 5, 32'hffff_fff7, 0);
    add_row(r_type(0, 1, 5, 2, 6), KIND_WBK, 6, 32'h1, 0);
    add_row(r_type(0, 1, 5, 3, 7), KIND_WBK, 7, 32'h0, 0);
    add_row(i_type(4, 1, 1, 8, 'h13), KIND_WBK, 8, 32'h50, 0);
    add_row(i_type('h402, 5, 5, 9, 'h13), KIND_WBK, 9, 32'hffff_fffd, 0);
    add_row(i_type(28, 5, 5, 10, 'h13), KIND_WBK, 10, 32'hf, 0);
    add_row(r_type(0, 2, 3, 7, 11), KIND_WBK, 11, 32'h8, 0);
    add_row(r_type(0, 2, 3, 6, 12), KIND_WBK, 12, 32'hd, 0);
    add_row(u_type('h12345, 13, 'h37), KIND_WBK, 13, 32'h1234_5000, 0);
    add_row(u_type(1, 14, 'h17), KIND_WBK, 14, 32'h0000_1138, 0);
    add_row(s_type('h40, 13, 0), KIND_STORE, 0, 32'h1234_5000, 32'h40);
    add_row(i_type('h40, 0, 2, 15, 'h03), KIND_WBK, 15, 32'h1234_5000, 0);
    add_row(i_type(1, 15, 0, 16, 'h13), KIND_WBK, 16, 32'h1234_5001, 0);
    // beq not taken then bne taken
    add_row(b_type(8, 2, 1, 0), KIND_NONE, 0, 0, 0);
    add_row(i_type(1, 0, 0, 17, 'h13), KIND_WBK, 17, 32'h1, 0);
    add_row(b_type(12, 2, 1, 1), KIND_NONE, 0, 0, 0);
    add_row(i_type('h77, 0, 0, 18, 'h13), KIND_NONE, 0, 0, 0);
    add_row(i_type('h77, 0, 0, 19, 'h13), KIND_NONE, 0, 0, 0);
    add_row(j_type(12, 20), KIND_WBK, 20, 32'h160, 0);
    add_row(i_type('h77, 0, 0, 18, 'h13), KIND_NONE, 0, 0, 0);
    add_row(i_type('h77, 0, 0, 19, 'h13), KIND_NONE, 0, 0, 0);
    // jalr to 0x179 lands on 0x178
    add_row(i_type('h178, 0, 0, 22, 'h13), KIND_WBK, 22, 32'h178, 0);
    add_row(i_type(1, 22, 0, 21, 'h67), KIND_WBK, 21, 32'h170, 0);
    add_row(i_type('h77, 0, 0, 18, 'h13), KIND_NONE, 0, 0, 0);
    add_row(i_type('h77, 0, 0, 19, 'h13), KIND_NONE, 0, 0, 0);
    add_row(b_type(8, 1, 5, 4), KIND_NONE, 0, 0, 0);
    add_row(i_type('h77, 0, 0, 18, 'h13), KIND_NONE, 0, 0, 0);
    add_row(b_type(8, 5, 1, 5), KIND_NONE, 0, 0, 0);
    add_row(i_type('h77, 0, 0, 19, 'h13), KIND_NONE, 0, 0, 0);
    add_row(i_type('hfff, 0, 0, 23, 'h13), KIND_WBK, 23, 32'hffff_ffff, 0);
    add_row(b_type(8, 1, 5, 5), KIND_NONE, 0, 0, 0);
    add_row(r_type(0, 23, 23, 0, 24), KIND_WBK, 24, 32'hffff_fffe, 0);
    // park on a self loop
    add_row(j_type(0, 0), KIND_NONE, 0, 0, 0);
  endtask

  initial begin
    reset_adr  = '0;
    n_rows     = 0;
    total_errs = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = `NOP_INSTR;
      dmem[i] <= 32'hd00d_0000 ^ (i * 4);
    end
    build_program();
    for (int k = 0; k < n_rows; k++) begin
      imem[BOOT_IDX + k] = prog[k].instr;
      if (prog[k].kind == KIND_WBK) begin
        u_checker.expect_wbk(prog[k].rd, prog[k].data, (BOOT_IDX + k) * 4);
      end else if (prog[k].kind == KIND_STORE) begin
        u_checker.expect_store(prog[k].adr, prog[k].data);
      end
    end
    @(posedge clk);
    #1 reset_adr = 32'h0000_0100;

    wait_cnt = 0;
    while (!chk_done && wait_cnt < WAIT_CYC) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (!chk_done) begin
      $display("checker did not finish within %0d cycles", WAIT_CYC);
      total_errs++;
    end
    total_errs += chk_errs;
    $display("errors: %0d", total_errs);
    if (total_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- tests/core_assert.sv
`timescale 1ns/1ps
`include "riscv_defines.svh"

module core_assert (
  input logic                clk,
  input logic                rst_n_i,
  input logic [`XLEN-1:0]    icache_adr_i,
  input riscv_pkg::mem_req_t mem_req_i,
  input riscv_pkg::wbk_t     wbk_i
);

  // x0 is never a destination
  a_no_x0_wbk: assert property (@(posedge clk) disable iff (!rst_n_i)
    wbk_i.valid |-> (wbk_i.adr != '0))
    else $error("write-back addressed to x0");

  a_word_access: assert property (@(posedge clk) disable iff (!rst_n_i)
    mem_req_i.valid |-> (mem_req_i.access_size == 3'b010))
    else $error("memory request with non-word access size");

  a_fetch_known: assert property (@(posedge clk) disable iff (!rst_n_i)
    !$isunknown(icache_adr_i))
    else $error("fetch address is unknown");

endmodule

//--- tests/core_checker.sv
`timescale 1ns/1ps
`include "riscv_defines.svh"

module core_checker #(
  parameter int TIMEOUT_CYC = 400
) (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic [`XLEN-1:0]    reset_adr_i,
  input  logic [`XLEN-1:0]    icache_adr_i,
  input  riscv_pkg::mem_req_t mem_req_i,
  input  riscv_pkg::wbk_t     wbk_i,
  input  logic [`XLEN-1:0]    pc_val_i,
  output logic                done_o,
  output int                  err_cnt_o
);
  import riscv_pkg::*;

  // expected streams in arrival order
  logic [2*`XLEN+`NB_REGS-1:0] wbk_q [$];
  logic [2*`XLEN-1:0]          store_q [$];
  logic [`XLEN-1:0]            exp_pc;
  logic [`NB_REGS-1:0]         exp_adr;
  logic [`XLEN-1:0]            exp_data;
  logic [`XLEN-1:0]            exp_mem_adr;
  // pc seen in execute one cycle before its write-back
  logic [`XLEN-1:0]            pc_val_q;
  int                          rst_cyc;
  int                          run_cyc;

  task automatic expect_wbk(input logic [`NB_REGS-1:0] adr, input logic [`XLEN-1:0] data,
                            input logic [`XLEN-1:0] pc);
    wbk_q.push_back({pc, adr, data});
  endtask

  task automatic expect_store(input logic [`XLEN-1:0] adr, input logic [`XLEN-1:0] data);
    store_q.push_back({adr, data});
  endtask

  initial begin
    done_o    = 1'b0;
    err_cnt_o = 0;
    rst_cyc   = 0;
    run_cyc   = 0;
  end

  // sampled mid-cycle where outputs are settled
  always @(negedge clk) begin
    if (!rst_n_i) begin
      rst_cyc++;
      if (wbk_i.valid || mem_req_i.valid) begin
        $display("write-back or memory request valid while in reset");
        err_cnt_o++;
      end
      if (rst_cyc >= 3 && icache_adr_i !== reset_adr_i) begin
        $display("FAIL icache_adr_o exp %h got %h", reset_adr_i, icache_adr_i);
        err_cnt_o++;
      end
    end else if (!done_o) begin
      if (run_cyc == 0 && icache_adr_i !== reset_adr_i) begin
        $display("FAIL icache_adr_o exp %h got %h", reset_adr_i, icache_adr_i);
        err_cnt_o++;
      end
      run_cyc++;
      if (wbk_i.valid) begin
        if (wbk_q.size() == 0) begin
          $display("write-back to x%0d seen with nothing left to expect", wbk_i.adr);
          err_cnt_o++;
        end else begin
          {exp_pc, exp_adr, exp_data} = wbk_q.pop_front();
          if (wbk_i.adr !== exp_adr) begin
            $display("FAIL wbk_o.adr exp %h got %h", exp_adr, wbk_i.adr);
            err_cnt_o++;
          end
          if (wbk_i.data !== exp_data) begin
            $display("FAIL wbk_o.data exp %h got %h", exp_data, wbk_i.data);
            err_cnt_o++;
          end
          if (pc_val_q !== exp_pc) begin
            $display("FAIL pc_val_o exp %h got %h", exp_pc, pc_val_q);
            err_cnt_o++;
          end
        end
      end
      if (mem_req_i.valid && mem_req_i.is_store) begin
        if (store_q.size() == 0) begin
          $display("store request seen with nothing left to expect");
          err_cnt_o++;
        end else begin
          {exp_mem_adr, exp_data} = store_q.pop_front();
          if (mem_req_i.adr !== exp_mem_adr) begin
            $display("FAIL mem_req_o.adr exp %h got %h", exp_mem_adr, mem_req_i.adr);
            err_cnt_o++;
          end
          if (mem_req_i.store_data !== exp_data) begin
            $display("FAIL mem_req_o.store_data exp %h got %h", exp_data, mem_req_i.store_data);
            err_cnt_o++;
          end
        end
      end
      if (wbk_q.size() == 0 && store_q.size() == 0) begin
        done_o = 1'b1;
      end else if (run_cyc > TIMEOUT_CYC) begin
        $display("expected results not all seen after %0d cycles", TIMEOUT_CYC);
        err_cnt_o++;
        done_o = 1'b1;
      end
    end
    pc_val_q = pc_val_i;
  end

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release shortly after a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

//--- verilog/core.sv
`timescale 1ns/1ps
`include "riscv_defines.svh"

module core (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic [`XLEN-1:0]    reset_adr_i,
  // --------------------
  // icache
  // --------------------
  output logic [`XLEN-1:0]    icache_adr_o,
  input  logic [31:0]         icache_instr_i,
  // --------------------
  // data memory
  // --------------------
  output riscv_pkg::mem_req_t mem_req_o,
  input  logic [`XLEN-1:0]    load_data_i,
  // checker outputs
  output riscv_pkg::wbk_t     wbk_o,
  output logic [`XLEN-1:0]    pc_val_o
);
  import riscv_pkg::*;

  // ifetch to dec
  if_dec_t             if_dec;
  // dec to rf
  logic [`NB_REGS-1:0] rs1_adr;
  logic [`NB_REGS-1:0] rs2_adr;
  logic [`XLEN-1:0]    rs1_data;
  logic [`XLEN-1:0]    rs2_data;
  // dec to exe and back
  dec_exe_t            dec_exe;
  wbk_t                exe_fwd;
  redirect_t           redirect;

  ifetch u_ifetch (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .reset_adr_i    (reset_adr_i),
    .icache_instr_i (icache_instr_i),
    .icache_adr_o   (icache_adr_o),
    .redirect_i     (redirect),
    .if_dec_o       (if_dec)
  );

  dec u_dec (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .if_dec_i   (if_dec),
    .rs1_adr_o  (rs1_adr),
    .rs2_adr_o  (rs2_adr),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .exe_fwd_i  (exe_fwd),
    .wbk_i      (wbk_o),
    .redirect_i (redirect),
    .dec_exe_o  (dec_exe)
  );

  rf u_rf (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rs1_adr_i  (rs1_adr),
    .rs2_adr_i  (rs2_adr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wbk_i      (wbk_o)
  );

  // write-back register also feeds rf and dec
  exe u_exe (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .dec_exe_i   (dec_exe),
    .mem_req_o   (mem_req_o),
    .load_data_i (load_data_i),
    .exe_fwd_o   (exe_fwd),
    .redirect_o  (redirect),
    .wbk_o       (wbk_o),
    .pc_val_o    (pc_val_o)
  );

endmodule

//--- verilog/exe.sv
`timescale 1ns/1ps
`include "riscv_defines.svh"

module exe (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  riscv_pkg::dec_exe_t  dec_exe_i,
  // --------------------
  // data memory
  // --------------------
  output riscv_pkg::mem_req_t  mem_req_o,
  input  logic [`XLEN-1:0]     load_data_i,
  // --------------------
  // dec, ifetch, wbk
  // --------------------
  output riscv_pkg::wbk_t      exe_fwd_o,
  output riscv_pkg::redirect_t redirect_o,
  output riscv_pkg::wbk_t      wbk_o,
  output logic [`XLEN-1:0]     pc_val_o
);
  import riscv_pkg::*;

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_res;
  logic [`XLEN-1:0] agu_adr;
  logic [`XLEN-1:0] link_adr;
  logic [`XLEN-1:0] result;
  logic             br_cond;

  assign op_a     = dec_exe_i.pc_rel ? dec_exe_i.pc : dec_exe_i.rs1_data;
  assign op_b     = dec_exe_i.use_imm ? dec_exe_i.imm : dec_exe_i.rs2_data;
  assign agu_adr  = dec_exe_i.rs1_data + dec_exe_i.imm;
  assign link_adr = dec_exe_i.pc + `XLEN'd4;

  // --------------------
  // alu
  // --------------------
  always_comb begin
    case (dec_exe_i.op)
      OP_SUB:  alu_res = op_a - op_b;
      OP_AND:  alu_res = op_a & op_b;
      OP_OR:   alu_res = op_a | op_b;
      OP_XOR:  alu_res = op_a ^ op_b;
      OP_SLT:  alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      OP_SLTU: alu_res = {{(`XLEN-1){1'b0}}, op_a < op_b};
      OP_SLL:  alu_res = op_a << op_b[4:0];
      OP_SRL:  alu_res = op_a >> op_b[4:0];
      OP_SRA:  alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
      default: alu_res = op_a + op_b;
    endcase
  end

  // branch compare on the raw register operands
  always_comb begin
    case (dec_exe_i.op)
      OP_BEQ:  br_cond = (dec_exe_i.rs1_data == dec_exe_i.rs2_data);
      OP_BNE:  br_cond = (dec_exe_i.rs1_data != dec_exe_i.rs2_data);
      OP_BLT:  br_cond = ($signed(dec_exe_i.rs1_data) < $signed(dec_exe_i.rs2_data));
      OP_BGE:  br_cond = ($signed(dec_exe_i.rs1_data) >= $signed(dec_exe_i.rs2_data));
      default: br_cond = 1'b0;
    endcase
  end

  always_comb begin
    redirect_o.taken = dec_exe_i.valid &&
                       ((dec_exe_i.unit == UNIT_BRANCH && br_cond) ||
                        (dec_exe_i.unit == UNIT_JUMP));
    // jalr drops bit 0 of its target
    redirect_o.pc    = dec_exe_i.jalr ? {agu_adr[`XLEN-1:1], 1'b0}
                                      : dec_exe_i.pc + dec_exe_i.imm;
  end

  // --------------------
  // data memory request
  // --------------------
  always_comb begin
    mem_req_o.valid       = dec_exe_i.valid &&
                            (dec_exe_i.unit == UNIT_LOAD || dec_exe_i.unit == UNIT_STORE);
    mem_req_o.adr         = agu_adr;
    mem_req_o.is_store    = (dec_exe_i.unit == UNIT_STORE);
    mem_req_o.store_data  = dec_exe_i.rs2_data;
    // word access only
    mem_req_o.access_size = 3'b010;
  end

  always_comb begin
    case (dec_exe_i.unit)
      UNIT_JUMP: result = link_adr;
      UNIT_LOAD: result = load_data_i;
      default:   result = alu_res;
    endcase
    exe_fwd_o.valid = dec_exe_i.valid && dec_exe_i.rd_v;
    exe_fwd_o.adr   = dec_exe_i.rd_adr;
    exe_fwd_o.data  = result;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wbk_o <= '0;
    end else begin
      wbk_o <= exe_fwd_o;
    end
  end

  assign pc_val_o = dec_exe_i.pc;

endmodule

//--- verilog/rf.sv
`timescale 1ns/1ps
`include "riscv_defines.svh"

module rf (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic [`NB_REGS-1:0] rs1_adr_i,
  input  logic [`NB_REGS-1:0] rs2_adr_i,
  output logic [`XLEN-1:0]    rs1_data_o,
  output logic [`XLEN-1:0]    rs2_data_o,
  input  riscv_pkg::wbk_t     wbk_i
);

  // x1 to x31, x0 has no storage
  logic [`XLEN-1:0] regs_q [1:31];

  assign rs1_data_o = (rs1_adr_i == '0) ? '0 : regs_q[rs1_adr_i];
  assign rs2_data_o = (rs2_adr_i == '0) ? '0 : regs_q[rs2_adr_i];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wbk_i.valid && (wbk_i.adr != '0)) begin
      regs_q[wbk_i.adr] <= wbk_i.data;
    end
  end

endmodule

//--- verilog/dec.sv
`timescale 1ns/1ps
`include "riscv_defines.svh"

module dec (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  riscv_pkg::if_dec_t   if_dec_i,
  // --------------------
  // register file
  // --------------------
  output logic [`NB_REGS-1:0]  rs1_adr_o,
  output logic [`NB_REGS-1:0]  rs2_adr_o,
  input  logic [`XLEN-1:0]     rs1_data_i,
  input  logic [`XLEN-1:0]     rs2_data_i,
  // --------------------
  // forwarding and flush
  // --------------------
  input  riscv_pkg::wbk_t      exe_fwd_i,
  input  riscv_pkg::wbk_t      wbk_i,
  input  riscv_pkg::redirect_t redirect_i,
  output riscv_pkg::dec_exe_t  dec_exe_o
);
  import riscv_pkg::*;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  logic [31:0]         instr;
  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`NB_REGS-1:0] rd;
  logic [`XLEN-1:0]    imm_i;
  logic [`XLEN-1:0]    imm_s;
  logic [`XLEN-1:0]    imm_b;
  logic [`XLEN-1:0]    imm_u;
  logic [`XLEN-1:0]    imm_j;
  logic                legal;
  logic                rd_write;
  dec_exe_t            dec_exe_d;

  // youngest producer first, then the write-back register, then the rf
  function automatic logic [`XLEN-1:0] fwd_operand(
    input logic [`NB_REGS-1:0] adr,
    input logic [`XLEN-1:0]    rf_data,
    input wbk_t                exe_fwd,
    input wbk_t                wbk
  );
    if (exe_fwd.valid && (exe_fwd.adr == adr) && (adr != '0)) begin
      return exe_fwd.data;
    end else if (wbk.valid && (wbk.adr == adr) && (adr != '0)) begin
      return wbk.data;
    end
    return rf_data;
  endfunction

  assign instr  = if_dec_i.instr;
  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // --------------------
  // immediates
  // --------------------
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // lui reads x0 so the alu adds zero
  assign rs1_adr_o = (opcode == OPC_LUI) ? '0 : instr[19:15];
  assign rs2_adr_o = instr[24:20];

  always_comb begin
    dec_exe_d         = '0;
    dec_exe_d.unit    = UNIT_ALU;
    dec_exe_d.op      = OP_ADD;
    legal             = 1'b1;
    rd_write          = 1'b0;
    case (opcode)
      OPC_OP, OPC_OP_IMM: begin
        rd_write          = 1'b1;
        dec_exe_d.use_imm = (opcode == OPC_OP_IMM);
        dec_exe_d.imm     = imm_i;
        case (funct3)
          3'b000: begin
            dec_exe_d.op = (opcode == OPC_OP && funct7[5]) ? OP_SUB : OP_ADD;
          end
          3'b001: dec_exe_d.op = OP_SLL;
          3'b010: dec_exe_d.op = OP_SLT;
          3'b011: dec_exe_d.op = OP_SLTU;
          3'b100: dec_exe_d.op = OP_XOR;
          3'b101: dec_exe_d.op = funct7[5] ? OP_SRA : OP_SRL;
          3'b110: dec_exe_d.op = OP_OR;
          default: dec_exe_d.op = OP_AND;
        endcase
      end
      OPC_LUI, OPC_AUIPC: begin
        rd_write          = 1'b1;
        dec_exe_d.use_imm = 1'b1;
        dec_exe_d.imm     = imm_u;
        dec_exe_d.pc_rel  = (opcode == OPC_AUIPC);
      end
      OPC_JAL, OPC_JALR: begin
        rd_write       = 1'b1;
        dec_exe_d.unit = UNIT_JUMP;
        dec_exe_d.jalr = (opcode == OPC_JALR);
        dec_exe_d.imm  = (opcode == OPC_JALR) ? imm_i : imm_j;
      end
      OPC_BRANCH: begin
        dec_exe_d.unit = UNIT_BRANCH;
        dec_exe_d.imm  = imm_b;
        case (funct3)
          3'b000: dec_exe_d.op = OP_BEQ;
          3'b001: dec_exe_d.op = OP_BNE;
          3'b100: dec_exe_d.op = OP_BLT;
          3'b101: dec_exe_d.op = OP_BGE;
          default: legal = 1'b0;
        endcase
      end
      OPC_LOAD: begin
        rd_write          = 1'b1;
        legal             = (funct3 == 3'b010);
        dec_exe_d.unit    = UNIT_LOAD;
        dec_exe_d.use_imm = 1'b1;
        dec_exe_d.imm     = imm_i;
      end
      OPC_STORE: begin
        legal          = (funct3 == 3'b010);
        dec_exe_d.unit = UNIT_STORE;
        dec_exe_d.imm  = imm_s;
      end
      default: legal = 1'b0;
    endcase

    // anything unsupported runs as a nop
    if (!legal) begin
      dec_exe_d.unit = UNIT_ALU;
      rd_write       = 1'b0;
    end

    dec_exe_d.pc       = if_dec_i.pc;
    dec_exe_d.rd_v     = rd_write && (rd != '0);
    dec_exe_d.rd_adr   = rd;
    dec_exe_d.rs1_data = fwd_operand(rs1_adr_o, rs1_data_i, exe_fwd_i, wbk_i);
    dec_exe_d.rs2_data = fwd_operand(rs2_adr_o, rs2_data_i, exe_fwd_i, wbk_i);
    dec_exe_d.valid    = ~redirect_i.taken;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec_exe_o <= '0;
    end else begin
      dec_exe_o <= dec_exe_d;
    end
  end

endmodule

//--- verilog/ifetch.sv
`timescale 1ns/1ps
`include "riscv_defines.svh"

module ifetch (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic [`XLEN-1:0]     reset_adr_i,
  // --------------------
  // icache
  // --------------------
  input  logic [31:0]          icache_instr_i,
  output logic [`XLEN-1:0]     icache_adr_o,
  // --------------------
  // exe and dec
  // --------------------
  input  riscv_pkg::redirect_t redirect_i,
  output riscv_pkg::if_dec_t   if_dec_o
);

  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] pc_next;

  assign icache_adr_o = pc_q;

  // taken branch or jump wins over sequential fetch
  assign pc_next = redirect_i.taken ? redirect_i.pc : pc_q + `XLEN'd4;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= reset_adr_i;
    end else begin
      pc_q <= pc_next;
    end
  end

  // fetch register, the word in flight is squashed on redirect
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      if_dec_o.instr <= `NOP_INSTR;
      if_dec_o.pc    <= '0;
    end else begin
      if_dec_o.instr <= redirect_i.taken ? `NOP_INSTR : icache_instr_i;
      if_dec_o.pc    <= pc_q;
    end
  end

endmodule

//--- verilog/riscv_pkg.sv
`include "riscv_defines.svh"

package riscv_pkg;

  // execute unit selection
  typedef enum logic [2:0] {
    UNIT_ALU    = 3'd0,
    UNIT_BRANCH = 3'd1,
    UNIT_JUMP   = 3'd2,
    UNIT_LOAD   = 3'd3,
    UNIT_STORE  = 3'd4
  } unit_e;

  // alu operations, branch compares share the encoding space
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLT  = 4'd5,
    OP_SLTU = 4'd6,
    OP_SLL  = 4'd7,
    OP_SRL  = 4'd8,
    OP_SRA  = 4'd9,
    OP_BEQ  = 4'd10,
    OP_BNE  = 4'd11,
    OP_BLT  = 4'd12,
    OP_BGE  = 4'd13
  } alu_op_e;

  // --------------------
  // stage payloads
  // --------------------

  typedef struct packed {
    logic [31:0]          instr;
    logic [`XLEN-1:0]     pc;
  } if_dec_t;

  typedef struct packed {
    logic [`XLEN-1:0]     pc;
    logic                 rd_v;
    logic [`NB_REGS-1:0]  rd_adr;
    logic [`XLEN-1:0]     rs1_data;
    logic [`XLEN-1:0]     rs2_data;
    logic [`XLEN-1:0]     imm;
    unit_e                unit;
    alu_op_e              op;
    logic                 use_imm;
    logic                 jalr;
    logic                 pc_rel;
    logic                 valid;
  } dec_exe_t;

  typedef struct packed {
    logic                 valid;
    logic [`NB_REGS-1:0]  adr;
    logic [`XLEN-1:0]     data;
  } wbk_t;

  typedef struct packed {
    logic                 valid;
    logic [`XLEN-1:0]     adr;
    logic                 is_store;
    logic [`XLEN-1:0]     store_data;
    logic [2:0]           access_size;
  } mem_req_t;

  typedef struct packed {
    logic                 taken;
    logic [`XLEN-1:0]     pc;
  } redirect_t;

endpackage

//--- verilog/riscv_defines.svh
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

// --------------------
// datapath widths
// --------------------

// data and address width
`define XLEN 32

// register address width, 32 architectural registers
`define NB_REGS 5

// --------------------
// encodings
// --------------------

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif
